/* filelist.f */
+incdir+verilog
verilog/axi_rd_pkg.sv
verilog/rd_cmd_setup.sv
verilog/ar_issuer.sv
verilog/rd_burst_fifo.sv
verilog/r_tracker.sv
verilog/axi_read_master.sv
dv/axi_rd_slave_model.sv
dv/tb_axi_read_master.sv

/* dv/tb_axi_read_master.sv */
// Testbench for the AXI4 read master
// Directed and random commands against a memory-mapped read responder
// AR requests and stream beats are checked against a reference model

`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module tb_axi_read_master;

  import axi_rd_pkg::*;

  localparam int DW_BYTES    = `AXI_RD_DW_BYTES;
  localparam int BURST_LEN   = `AXI_RD_BURST_LEN;
  localparam int BURST_BYTES = `AXI_RD_BURST_BYTES;
  localparam int MAX_OUT     = `AXI_RD_MAX_OUTSTANDING;
  localparam int NUM_CMDS    = 9;
  localparam int STALL_CYCLES = 3000;

  // Stream ready modes
  localparam int TREADY_ON   = 0;
  localparam int TREADY_OFF  = 1;
  localparam int TREADY_RAND = 2;

  logic        aclk;
  logic        areset;
  logic        ctrl_start;
  xfer_cmd_t   ctrl_cmd;
  logic        ctrl_done;
  logic        m_axi_arvalid;
  logic        m_axi_arready;
  ar_req_t     m_axi_ar;
  logic        m_axi_rvalid;
  logic        m_axi_rready;
  r_beat_t     m_axi_r;
  logic        m_axis_tvalid;
  logic        m_axis_tready;
  r_beat_t     m_axis_t;

  integer      seed;
  int          tready_mode;
  int          error_count;
  int          timeout_cycles;
  int          total_beats;
  int          cmds_started;
  int          done_count;
  int          exp_bursts;
  int          rlast_seen;
  int          in_flight;
  logic        done_prev;
  logic        rlast_prev;
  xfer_cmd_t   cmds [NUM_CMDS];

  // Expected traffic, in order
  ar_req_t     exp_ar [$];
  r_beat_t     exp_beats [$];
  ar_req_t     exp_req;
  r_beat_t     exp_beat;

  axi_read_master u_dut (
    .aclk          (aclk),
    .areset        (areset),
    .ctrl_start    (ctrl_start),
    .ctrl_cmd      (ctrl_cmd),
    .ctrl_done     (ctrl_done),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_ar      (m_axi_ar),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rready  (m_axi_rready),
    .m_axi_r       (m_axi_r),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_t      (m_axis_t)
  );

  axi_rd_slave_model #(
    .SEED (32'h9ab2cef5)
  ) u_slave (
    .aclk    (aclk),
    .areset  (areset),
    .arvalid (m_axi_arvalid),
    .arready (m_axi_arready),
    .ar      (m_axi_ar),
    .rvalid  (m_axi_rvalid),
    .rready  (m_axi_rready),
    .r       (m_axi_r)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t ns: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "check failed");
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Whole words from the burst-aligned base in full bursts and a final remainder
  function automatic void build_expected(input xfer_cmd_t cmd);
    logic [63:0] beats_left;
    logic [63:0] burst_addr;
    int          burst_beats;
    ar_req_t     req;
    r_beat_t     beat;
    beats_left = (64'(cmd.xfer_size) + DW_BYTES - 1) / DW_BYTES;
    burst_addr = cmd.addr - (cmd.addr % BURST_BYTES);
    while (beats_left != 0) begin
      burst_beats = (beats_left > BURST_LEN) ? BURST_LEN : int'(beats_left);
      req.addr    = burst_addr;
      req.len     = 8'(burst_beats - 1);
      exp_ar.push_back(req);
      for (int i = 0; i < burst_beats; i++) begin
        beat.data = 32'(burst_addr + 64'(i * DW_BYTES));
        beat.last = (i == burst_beats - 1);
        exp_beats.push_back(beat);
      end
      exp_bursts++;
      beats_left -= burst_beats;
      burst_addr += BURST_BYTES;
    end
  endfunction

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic start_command(input xfer_cmd_t cmd);
    // No stray done before this command
    check_equal(done_count, cmds_started, "done pulses before new command");
    build_expected(cmd);
    cmds_started++;
    @(posedge aclk);
    ctrl_cmd   <= cmd;
    ctrl_start <= 1'b1;
    @(posedge aclk);
    ctrl_start <= 1'b0;
  endtask

  task automatic wait_done();
    while (done_count < cmds_started) @(negedge aclk);
  endtask

  task automatic wait_drained();
    while (exp_beats.size() != 0) @(negedge aclk);
  endtask

  // Stream back-pressure
  always @(posedge aclk) begin
    if (areset || tready_mode == TREADY_OFF) begin
      m_axis_tready <= 1'b0;
    end else if (tready_mode == TREADY_ON) begin
      m_axis_tready <= 1'b1;
    end else begin
      m_axis_tready <= {$random(seed)} % 2;
    end
  end

  //////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (!areset) begin
      // R channel is never stalled
      check_equal(m_axi_rready, 1, "rready held high");
      if (m_axi_arvalid && m_axi_arready) begin
        check_equal(exp_ar.size() != 0, 1, "AR request expected");
        exp_req = exp_ar.pop_front();
        check_equal(m_axi_ar.addr, exp_req.addr, "AR address");
        check_equal(m_axi_ar.len, exp_req.len, "AR len");
        in_flight++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        check_equal(exp_beats.size() != 0, 1, "stream beat expected");
        exp_beat = exp_beats.pop_front();
        check_equal(m_axis_t.data, exp_beat.data, "stream data");
        check_equal(m_axis_t.last, exp_beat.last, "stream last");
        if (m_axis_t.last) begin
          in_flight--;
        end
      end
      check_equal(in_flight <= MAX_OUT, 1, "bursts in flight within limit");
      // Done follows the final R last by one cycle
      if (ctrl_done) begin
        check_equal(done_prev, 0, "done high for one cycle only");
        check_equal(rlast_prev, 1, "done one cycle after R last");
        check_equal(rlast_seen, exp_bursts, "R bursts returned at done");
        done_count++;
      end
      done_prev  = ctrl_done;
      rlast_prev = m_axi_rvalid && m_axi_rready && m_axi_r.last;
      if (rlast_prev) begin
        rlast_seen++;
      end
    end
  end

  // Limit from the total beat count of all commands
  initial begin : watchdog
    wait (timeout_cycles != 0);
    repeat (timeout_cycles) @(posedge aclk);
    $display("Timeout after %0d clock cycles, the transfers did not complete", timeout_cycles);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    seed          = 32'h9ab2cef5;
    areset        = 1'b1;
    ctrl_start    = 1'b0;
    ctrl_cmd      = '0;
    m_axis_tready = 1'b0;
    tready_mode   = TREADY_ON;
    error_count   = 0;
    timeout_cycles = 0;
    total_beats   = 0;
    cmds_started  = 0;
    done_count    = 0;
    exp_bursts    = 0;
    rlast_seen    = 0;
    in_flight     = 0;
    done_prev     = 1'b0;
    rlast_prev    = 1'b0;

    // Directed sizes, then random ones
    cmds[0].addr      = 64'h0000_0000_1000_0123;
    cmds[0].xfer_size = 32'd100;
    cmds[1].addr      = 64'h0000_0002_0000_0a10;
    cmds[1].xfer_size = 32'd2600;
    cmds[2].addr      = 64'h0000_00ff_fff0_0404;
    cmds[2].xfer_size = 32'd6000;
    for (int i = 3; i < NUM_CMDS; i++) begin
      cmds[i].addr      = {$random(seed), $random(seed)};
      cmds[i].xfer_size = ({$random(seed)} % 6000) + 1;
    end
    for (int i = 0; i < NUM_CMDS; i++) begin
      total_beats += (cmds[i].xfer_size + DW_BYTES - 1) / DW_BYTES;
    end
    timeout_cycles = total_beats * 12 + STALL_CYCLES + 4000;

    repeat (5) @(posedge aclk);
    areset <= 1'b0;

    // Quiet outputs before any start
    repeat (8) begin
      @(negedge aclk);
      check_equal(m_axi_arvalid, 0, "arvalid after reset");
      check_equal(m_axis_tvalid, 0, "tvalid after reset");
      check_equal(ctrl_done, 0, "done after reset");
    end

    // Single partial burst
    start_command(cmds[0]);
    wait_done();
    wait_drained();

    // Three bursts with a random stream
    tready_mode = TREADY_RAND;
    start_command(cmds[1]);
    wait_done();
    wait_drained();

    // Stalled stream fills every slot, then drains at random
    tready_mode = TREADY_OFF;
    start_command(cmds[2]);
    repeat (STALL_CYCLES) @(negedge aclk);
    check_equal(in_flight, MAX_OUT, "bursts in flight under back-pressure");
    check_equal(done_count, cmds_started - 1, "done while stream stalled");
    tready_mode = TREADY_RAND;
    wait_done();

    // Back-to-back random commands, each after the previous done
    for (int i = 3; i < NUM_CMDS; i++) begin
      start_command(cmds[i]);
      wait_done();
    end
    wait_drained();
    repeat (20) @(negedge aclk);
    check_equal(done_count, NUM_CMDS, "done pulse count");
    check_equal(in_flight, 0, "bursts left in flight");
    check_equal(exp_ar.size(), 0, "AR requests missing");

    if (error_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "errors found");
    end
  end

endmodule

`default_nettype wire

/* dv/axi_rd_slave_model.sv */
// AXI4 read responder for the testbench
// Each beat returns the low 32 bits of its own byte address
// arready and rvalid come with random gaps, requests queue in order

`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module axi_rd_slave_model #(
  parameter logic [31:0] SEED = 32'h0
) (
  input  wire                      aclk,
  input  wire                      areset,
  input  wire                      arvalid,
  output logic                     arready,
  input  wire axi_rd_pkg::ar_req_t ar,
  output logic                     rvalid,
  input  wire                      rready,
  output axi_rd_pkg::r_beat_t      r
);

  import axi_rd_pkg::*;

  localparam int DW_BYTES = `AXI_RD_DW_BYTES;

  integer  seed;

  // Accepted requests, front one is being answered
  ar_req_t pending [$];

  // Beat on offer, or the next one to offer during a gap
  int      beat_idx;

  initial begin
    seed     = SEED;
    arready  = 1'b0;
    rvalid   = 1'b0;
    r        = '0;
    beat_idx = 0;
  end

  always @(posedge aclk) begin
    if (areset) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      r        <= '0;
      beat_idx = 0;
      pending.delete();
    end else begin
      // Retire the beat taken on this edge
      if (rvalid && rready) begin
        if (r.last) begin
          pending.delete(0);
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      // Offer the next beat or insert a gap
      if (!rvalid || rready) begin
        if (pending.size() != 0 && ({$random(seed)} % 3) != 0) begin
          rvalid <= 1'b1;
          r.data <= 32'(pending[0].addr + 64'(beat_idx * DW_BYTES));
          r.last <= (beat_idx == int'(pending[0].len));
        end else begin
          rvalid <= 1'b0;
        end
      end
      // New request joins the queue after this edge
      if (arvalid && arready) begin
        pending.push_back(ar);
      end
      arready <= ({$random(seed)} % 4) != 0;
    end
  end

endmodule

`default_nettype wire

/* verilog/axi_read_master.sv */
// AXI4 read master top level
// Reads a byte range in full bursts and streams the words out
// rready stays high, the buffer holds every burst in flight

`timescale 1ns/1ps
`default_nettype none

module axi_read_master (
  input  wire                      aclk,
  input  wire                      areset,

  // Control
  input  wire                      ctrl_start,
  input  wire axi_rd_pkg::xfer_cmd_t ctrl_cmd,
  output logic                     ctrl_done,

  // AR channel
  output logic                     m_axi_arvalid,
  input  wire                      m_axi_arready,
  output axi_rd_pkg::ar_req_t      m_axi_ar,

  // R channel
  input  wire                      m_axi_rvalid,
  output logic                     m_axi_rready,
  input  wire axi_rd_pkg::r_beat_t m_axi_r,

  // Stream out
  output logic                     m_axis_tvalid,
  input  wire                      m_axis_tready,
  output axi_rd_pkg::r_beat_t      m_axis_t
);

  import axi_rd_pkg::*;

  logic        start;
  burst_plan_t plan;
  logic        burst_drained;
  logic        rxfer;

  // Buffer always has room for what was requested
  assign m_axi_rready = 1'b1;
  assign rxfer        = m_axi_rvalid & m_axi_rready;

  rd_cmd_setup u_cmd_setup (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_cmd   (ctrl_cmd),
    .start      (start),
    .plan       (plan)
  );

  ar_issuer u_ar_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .plan          (plan),
    .burst_drained (burst_drained),
    .arvalid       (m_axi_arvalid),
    .arready       (m_axi_arready),
    .ar            (m_axi_ar)
  );

  rd_burst_fifo u_burst_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .wr_en         (rxfer),
    .wr_beat       (m_axi_r),
    .tvalid        (m_axis_tvalid),
    .tready        (m_axis_tready),
    .t             (m_axis_t),
    .burst_drained (burst_drained)
  );

  r_tracker u_r_tracker (
    .aclk   (aclk),
    .areset (areset),
    .start  (start),
    .plan   (plan),
    .rvalid (rxfer),
    .rlast  (m_axi_r.last),
    .done   (ctrl_done)
  );

endmodule

`default_nettype wire

/* verilog/r_tracker.sv */
// Tracks completed bursts on the R channel
// One-cycle done after the last beat of the final burst

`timescale 1ns/1ps
`default_nettype none

module r_tracker (
  input  wire                      aclk,
  input  wire                      areset,
  input  wire                      start,
  input  wire axi_rd_pkg::burst_plan_t plan,
  input  wire                      rvalid,
  input  wire                      rlast,
  output logic                     done
);

  // Bursts still expected, zero means the final one
  logic [$bits(plan.num_bursts)-1:0] bursts_left;

  // Burst end on the R channel
  logic                             burst_end;

  assign burst_end = rvalid & rlast;

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (start) begin
      bursts_left <= plan.num_bursts;
    end else if (burst_end) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  // Registered pulse, high the cycle after the final last beat
  always_ff @(posedge aclk) begin
    if (areset) begin
      done <= 1'b0;
    end else begin
      done <= burst_end & (bursts_left == '0);
    end
  end

endmodule

`default_nettype wire

/* verilog/rd_burst_fifo.sv */
// Read data buffer between the R channel and the stream output
// First-word-fall-through, sized for every burst in flight
// Flags the stream side each time a burst's last beat leaves

`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module rd_burst_fifo (
  input  wire                  aclk,
  input  wire                  areset,
  input  wire                  wr_en,
  input  wire axi_rd_pkg::r_beat_t wr_beat,
  output logic                 tvalid,
  input  wire                  tready,
  output axi_rd_pkg::r_beat_t  t,
  output logic                 burst_drained
);

  import axi_rd_pkg::*;

  localparam int DEPTH = `AXI_RD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  // Beat storage
  r_beat_t           mem [DEPTH];

  // Pointers wrap on their own, depth is a power of two
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;

  // Occupancy, one extra bit for a full buffer
  logic [PTR_W:0]    count;

  logic              rd_en;

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // Issuer limit keeps writes away from a full buffer
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Head entry shows as soon as it is written
  assign tvalid = (count != '0);
  assign t      = mem[rd_ptr];
  assign rd_en  = tvalid & tready;

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // End of one burst on the stream, frees an issuer slot
  assign burst_drained = rd_en & t.last;

endmodule

`default_nettype wire

/* verilog/ar_issuer.sv */
// AR channel driver of the read master
// Steps through the burst plan, one request per free buffer slot
// Slots return when a burst's last beat leaves the buffer

`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module ar_issuer (
  input  wire                      aclk,
  input  wire                      areset,
  input  wire                      start,
  input  wire axi_rd_pkg::burst_plan_t plan,
  input  wire                      burst_drained,
  output logic                     arvalid,
  input  wire                      arready,
  output axi_rd_pkg::ar_req_t      ar
);

  import axi_rd_pkg::*;

  localparam int SLOT_W = $clog2(`AXI_RD_MAX_OUTSTANDING + 1);
  localparam logic [SLOT_W-1:0] SLOTS_INIT = `AXI_RD_MAX_OUTSTANDING;

  ar_state_t                        state;
  ar_state_t                        state_next;

  // Current burst address
  logic [`AXI_RD_ADDR_W-1:0]        addr_r;

  // Bursts still to issue, zero means the current one is the last
  logic [$bits(plan.num_bursts)-1:0] bursts_left;
  logic                             final_burst;

  // Buffer slots not yet claimed by an issued burst
  logic [SLOT_W-1:0]                free_slots;
  logic                             slot_free;

  logic                             arxfer;

  assign arxfer      = arvalid & arready;
  assign final_burst = (bursts_left == '0);
  assign slot_free   = (free_slots != '0);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      AR_IDLE: begin
        if (start) begin
          state_next = slot_free ? AR_VALID : AR_WAIT_SLOT;
        end
      end
      AR_WAIT_SLOT: begin
        if (slot_free) begin
          state_next = AR_VALID;
        end
      end
      AR_VALID: begin
        // Hold until accepted, then one idle cycle before the next request
        if (arready) begin
          state_next = final_burst ? AR_IDLE : AR_WAIT_SLOT;
        end
      end
      default: state_next = AR_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= AR_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign arvalid = (state == AR_VALID);

  //////////////////////////////////////////////////
  // Address and burst count
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (start) begin
      addr_r <= plan.base_addr;
    end else if (arxfer) begin
      addr_r <= addr_r + `AXI_RD_BURST_BYTES;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (start) begin
      bursts_left <= plan.num_bursts;
    end else if (arxfer) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  // Claimed on acceptance, released on drain
  always_ff @(posedge aclk) begin
    if (areset) begin
      free_slots <= SLOTS_INIT;
    end else begin
      case ({burst_drained, arxfer})
        2'b10:   free_slots <= free_slots + 1'b1;
        2'b01:   free_slots <= free_slots - 1'b1;
        default: free_slots <= free_slots;
      endcase
    end
  end

  // Full bursts except the last one
  assign ar.addr = addr_r;
  assign ar.len  = final_burst ? plan.final_len : 8'(`AXI_RD_BURST_LEN - 1);

endmodule

`default_nettype wire

/* verilog/rd_cmd_setup.sv */
// Turns a start command into a burst plan
// Two register stages, plan and start pulse come out together

`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module rd_cmd_setup (
  input  wire                     aclk,
  input  wire                     areset,
  input  wire                     ctrl_start,
  input  wire axi_rd_pkg::xfer_cmd_t ctrl_cmd,
  output logic                    start,
  output axi_rd_pkg::burst_plan_t plan
);

  localparam int LOG_DW      = `AXI_RD_LOG_DW_BYTES;
  localparam int LOG_BL      = `AXI_RD_LOG_BURST_LEN;
  localparam int TOTAL_LEN_W = `AXI_RD_XFER_W - LOG_DW;
  localparam logic [`AXI_RD_ADDR_W-1:0] ADDR_MASK = `AXI_RD_BURST_BYTES - 1;

  // Start pipeline
  logic                      start_d1;

  // First stage, beats minus one and aligned base
  logic [TOTAL_LEN_W-1:0]    total_len_r;
  logic [`AXI_RD_ADDR_W-1:0] base_addr_r;

  // Size has bytes beyond the last whole word
  logic                      partial_word;

  assign partial_word = |ctrl_cmd.xfer_size[LOG_DW-1:0];

  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  //////////////////////////////////////////////////
  // Stage 1 on the start edge
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // A partial word adds one beat, which cancels the minus one
      total_len_r <= partial_word ? ctrl_cmd.xfer_size[LOG_DW +: TOTAL_LEN_W]
                                  : ctrl_cmd.xfer_size[LOG_DW +: TOTAL_LEN_W] - 1'b1;
      // Down to a full-burst boundary
      base_addr_r <= ctrl_cmd.addr & ~ADDR_MASK;
    end
  end

  //////////////////////////////////////////////////
  // Stage 2 splits the length into bursts
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (start_d1) begin
      plan.base_addr  <= base_addr_r;
      // Upper bits count full bursts minus one
      plan.num_bursts <= total_len_r[LOG_BL +: TOTAL_LEN_W-LOG_BL];
      // Low bits are the len of the last burst
      plan.final_len  <= total_len_r[LOG_BL-1:0];
    end
  end

endmodule

`default_nettype wire

/* verilog/axi_rd_pkg.sv */
// Shared types of the AXI4 read master
// Command, AR request, R/stream beat, burst plan and issuer states

`default_nettype none

`include "axi_rd_macros.svh"

package axi_rd_pkg;

  // Start command, size in bytes
  typedef struct packed {
    logic [`AXI_RD_ADDR_W-1:0] addr;
    logic [`AXI_RD_XFER_W-1:0] xfer_size;
  } xfer_cmd_t;

  // Reduced AR channel payload, len is beats minus one
  typedef struct packed {
    logic [`AXI_RD_ADDR_W-1:0] addr;
    logic [7:0]                len;
  } ar_req_t;

  // One data beat, shared by the R channel and the stream
  typedef struct packed {
    logic                      last;
    logic [`AXI_RD_DATA_W-1:0] data;
  } r_beat_t;

  // Burst split of one command
  typedef struct packed {
    logic [`AXI_RD_ADDR_W-1:0]                                           base_addr;
    logic [`AXI_RD_XFER_W-`AXI_RD_LOG_DW_BYTES-`AXI_RD_LOG_BURST_LEN-1:0] num_bursts;
    logic [`AXI_RD_LOG_BURST_LEN-1:0]                                    final_len;
  } burst_plan_t;

  // Address issuer FSM
  typedef enum logic [1:0] {
    AR_IDLE,
    AR_WAIT_SLOT,
    AR_VALID
  } ar_state_t;

endpackage

`default_nettype wire

/* verilog/axi_rd_macros.svh */
// Width and sizing constants for the AXI4 read master
// Included by the package and by every block that needs a size

`ifndef AXI_RD_MACROS_SVH
`define AXI_RD_MACROS_SVH

// Bus and command widths
`define AXI_RD_ADDR_W           64
`define AXI_RD_DATA_W           32
`define AXI_RD_XFER_W           32

// One beat of data
`define AXI_RD_DW_BYTES         (`AXI_RD_DATA_W / 8)
`define AXI_RD_LOG_DW_BYTES     $clog2(`AXI_RD_DW_BYTES)

// AXI protocol burst limits
`define AXI_RD_MAX_BURST_LEN    256
`define AXI_RD_MAX_BURST_BYTES  4096

// Full burst, limited by beat count or by the 4 KB boundary
`define AXI_RD_BURST_LEN        (((`AXI_RD_MAX_BURST_BYTES / `AXI_RD_DW_BYTES) < \
                                  `AXI_RD_MAX_BURST_LEN) ? \
                                 (`AXI_RD_MAX_BURST_BYTES / `AXI_RD_DW_BYTES) : \
                                 `AXI_RD_MAX_BURST_LEN)
`define AXI_RD_LOG_BURST_LEN    $clog2(`AXI_RD_BURST_LEN)
`define AXI_RD_BURST_BYTES      (`AXI_RD_BURST_LEN * `AXI_RD_DW_BYTES)

// Bursts in flight
`define AXI_RD_MAX_OUTSTANDING  4

// Holds every burst in flight, rounded to a power of two
`define AXI_RD_FIFO_DEPTH       (2 ** $clog2(`AXI_RD_BURST_LEN * `AXI_RD_MAX_OUTSTANDING))

`endif
